//--- hw/cast_fmt_pkg.sv
/* FP32 and INT32 format definitions */

package cast_fmt_pkg;

  // ------------------------------------------------
  // Format widths
  // ------------------------------------------------
  localparam int unsigned FP_WIDTH  = 32;
  localparam int unsigned EXP_BITS  = 8;
  localparam int unsigned MAN_BITS  = 23;
  localparam int unsigned BIAS      = 127;
  localparam int unsigned INT_WIDTH = 32;

  // Internal mantissa holds the hidden bit plus fraction, or a whole integer
  localparam int unsigned INT_MAN_WIDTH = (MAN_BITS + 1 > INT_WIDTH) ? MAN_BITS + 1 : INT_WIDTH;
  localparam int unsigned LZC_WIDTH     = $clog2(INT_MAN_WIDTH);
  localparam int unsigned INT_EXP_WIDTH = 10; // Covers -150 .. +264 unbiased
  localparam int unsigned SHAMT_WIDTH   = $clog2(INT_MAN_WIDTH + 1); // Denorm shifter amount

  localparam logic [MAN_BITS-1:0] QNAN_MAN = 1 << (MAN_BITS - 1); // Quiet bit of a NaN

  // ------------------------------------------------
  // Operand views
  // ------------------------------------------------
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent; // Biased
    logic [MAN_BITS-1:0] mantissa; // Fraction, hidden bit dropped
  } fp32_t;

  // One operand word, read as a float for F2I or as an integer for I2F
  typedef union packed {
    fp32_t                fp;
    logic [INT_WIDTH-1:0] ival;
  } cast_operand_u;

endpackage

//--- hw/cast_op_pkg.sv
/* Cast operation and pipeline payloads */

package cast_op_pkg;

  typedef enum logic [1:0] {
    F2I = 2'd0, // Float to integer
    I2F = 2'd1  // Integer to float
  } op_e;

  typedef enum logic [2:0] {
    RNE = 3'b000, // Nearest, ties to even
    RTZ = 3'b001, // Toward zero
    RDN = 3'b010, // Toward minus infinity
    RUP = 3'b011, // Toward plus infinity
    RMM = 3'b100  // Nearest, ties away from zero
  } rnd_mode_e;

  typedef struct packed {
    logic NV; // Invalid
    logic DZ; // Divide by zero, never raised here
    logic OF; // Overflow
    logic UF; // Underflow
    logic NX; // Inexact
  } status_t;

  // ------------------------------------------------
  // Stage payloads
  // ------------------------------------------------
  typedef struct packed {
    cast_fmt_pkg::cast_operand_u operand;
    op_e                         op;
    logic                        op_mod;   // High selects unsigned integers
    rnd_mode_e                   rnd_mode;
  } cast_req_t;

  typedef struct packed {
    logic                                     sign;
    logic [cast_fmt_pkg::INT_EXP_WIDTH-1:0]   exponent; // Unbiased, two's complement
    logic [cast_fmt_pkg::INT_MAN_WIDTH-1:0]   mantissa; // Left aligned
    logic                                     mant_is_zero;
    logic                                     is_nan;
    logic                                     is_signalling;
    logic                                     is_inf;
    op_e                                      op;
    logic                                     op_mod;
    rnd_mode_e                                rnd_mode;
  } norm_t;

  typedef struct packed {
    logic [cast_fmt_pkg::INT_WIDTH-1:0] rounded_abs;  // Magnitude or {exp, man}
    logic                               rounded_sign;
    logic [1:0]                         fp_round_sticky;
    logic [1:0]                         int_round_sticky;
    logic                               of_before_round;
    logic                               uf_before_round;
    logic                               mant_is_zero;
    logic                               is_nan;
    logic                               is_inf;
    op_e                                op;
    logic                               op_mod;
  } round_t;

  typedef struct packed {
    logic [cast_fmt_pkg::FP_WIDTH-1:0] result;
    status_t                           status;
  } cast_rsp_t;

endpackage

//--- hw/cast_pipe_stage.sv
/* Valid/ready register stage */

`timescale 1ns/1ps

module cast_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Advance when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i; // Bubble in if nothing offered
    end
  end

  // Payload loads only on an accepted item
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_o <= data_i;
    end
  end

  // A stalled item stays put until downstream accepts it
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

  a_reset_empty: assert property (@(posedge clk_i) rst_i |=> !valid_o);

endmodule

//--- hw/cast_normalize.sv
/* Operand decode and normalization */

`timescale 1ns/1ps

module cast_normalize (
  input  cast_op_pkg::cast_req_t req_i,
  output cast_op_pkg::norm_t     norm_o
);

  cast_fmt_pkg::fp32_t                    fp_in;        // Float view of the operand
  logic [cast_fmt_pkg::INT_WIDTH-1:0]     int_in;       // Integer view of the operand
  logic                                   src_is_int;
  logic                                   exp_zero;
  logic                                   exp_ones;
  logic                                   man_nonzero;
  logic                                   is_normal;
  logic                                   is_subnormal;
  logic                                   is_nan;
  logic                                   is_inf;
  logic                                   int_sign;
  logic [cast_fmt_pkg::INT_MAN_WIDTH-1:0] int_mant;
  logic [cast_fmt_pkg::INT_MAN_WIDTH-1:0] fp_mant;
  logic [cast_fmt_pkg::INT_MAN_WIDTH-1:0] encoded_mant;
  logic [cast_fmt_pkg::LZC_WIDTH-1:0]     lzc_cnt;
  logic                                   mant_is_zero;

  assign fp_in      = req_i.operand.fp;
  assign int_in     = req_i.operand.ival;
  assign src_is_int = (req_i.op == cast_op_pkg::I2F);

  // ------------------------------------------------
  // FP32 classification
  // ------------------------------------------------
  assign exp_zero     = (fp_in.exponent == '0);
  assign exp_ones     = (fp_in.exponent == '1);
  assign man_nonzero  = |fp_in.mantissa;
  assign is_normal    = ~exp_zero & ~exp_ones;
  assign is_subnormal = exp_zero & man_nonzero; // Zero itself shows up as mant_is_zero
  assign is_inf       = exp_ones & ~man_nonzero;
  assign is_nan       = exp_ones & man_nonzero;

  // ------------------------------------------------
  // Mantissa source
  // ------------------------------------------------
  // Only signed integers can be negative
  assign int_sign = int_in[cast_fmt_pkg::INT_WIDTH-1] & ~req_i.op_mod;
  assign int_mant = int_sign ? -int_in : int_in;

  // Hidden bit plus fraction, zero padded above
  assign fp_mant = {{(cast_fmt_pkg::INT_MAN_WIDTH - cast_fmt_pkg::MAN_BITS - 1){1'b0}},
                    is_normal, fp_in.mantissa};

  assign encoded_mant = src_is_int ? int_mant : fp_mant;

  always_comb begin : normalize
    int exp_val;
    // Leading zero count, scanning down from the MSB
    lzc_cnt      = '0;
    mant_is_zero = 1'b1;
    for (int i = cast_fmt_pkg::INT_MAN_WIDTH - 1; i >= 0; i--) begin
      if (mant_is_zero) begin
        if (encoded_mant[i]) begin
          mant_is_zero = 1'b0; // First one found, count frozen
        end else begin
          lzc_cnt = lzc_cnt + 1'b1;
        end
      end
    end

    // Unbias and compensate for the normalizing shift
    if (src_is_int) begin
      exp_val = int'(cast_fmt_pkg::INT_MAN_WIDTH) - 1 - int'(lzc_cnt);
    end else begin
      exp_val = int'(fp_in.exponent) + int'(is_subnormal) - int'(cast_fmt_pkg::BIAS)
                - int'(lzc_cnt)
                + int'(cast_fmt_pkg::INT_MAN_WIDTH) - 1 - int'(cast_fmt_pkg::MAN_BITS);
    end

    norm_o               = '0;
    norm_o.sign          = src_is_int ? int_sign : fp_in.sign;
    norm_o.exponent      = exp_val[cast_fmt_pkg::INT_EXP_WIDTH-1:0];
    norm_o.mantissa      = encoded_mant << lzc_cnt; // Leading one to the MSB
    norm_o.mant_is_zero  = mant_is_zero;
    norm_o.is_nan        = is_nan;  // Meaningful for F2I only
    norm_o.is_signalling = is_nan & ~|(fp_in.mantissa & cast_fmt_pkg::QNAN_MAN);
    norm_o.is_inf        = is_inf;
    norm_o.op            = req_i.op;
    norm_o.op_mod        = req_i.op_mod;
    norm_o.rnd_mode      = req_i.rnd_mode;
  end

  // Opcode reaching the datapath must be one of the two casts
  always_comb begin
    if (!$isunknown(req_i.op)) begin
      a_legal_op: assert (req_i.op inside {cast_op_pkg::F2I, cast_op_pkg::I2F})
        else $error("illegal cast op %0d", req_i.op);
    end
  end

endmodule

//--- hw/cast_denorm_round.sv
/* Range check, denormalize and round */

`timescale 1ns/1ps

module cast_denorm_round (
  input  cast_op_pkg::norm_t  norm_i,
  output cast_op_pkg::round_t round_o
);

  logic                                     src_is_int;
  logic [cast_fmt_pkg::EXP_BITS-1:0]        final_exp;
  logic [2*cast_fmt_pkg::INT_MAN_WIDTH:0]   preshift_mant;   // Mantissa left of the shifter
  logic [2*cast_fmt_pkg::INT_MAN_WIDTH:0]   dest_mant;       // After the right shift
  logic [cast_fmt_pkg::SHAMT_WIDTH-1:0]     denorm_shamt;
  logic [cast_fmt_pkg::MAN_BITS-1:0]        final_mant;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]       final_int;
  logic [1:0]                               fp_rs;
  logic [1:0]                               int_rs;
  logic [1:0]                               round_sticky;
  logic                                     of_range;
  logic                                     uf_range;
  logic [cast_fmt_pkg::INT_WIDTH-1:0]       pre_round_abs;
  logic                                     round_up;
  logic [cast_fmt_pkg::INT_WIDTH:0]         round_sum;       // Carry kept on top

  assign src_is_int    = (norm_i.op == cast_op_pkg::I2F);
  assign preshift_mant = {norm_i.mantissa, {(cast_fmt_pkg::INT_MAN_WIDTH + 1){1'b0}}};

  // ------------------------------------------------
  // Shift amount and range
  // ------------------------------------------------
  always_comb begin : cast_value
    int in_exp;
    int dst_exp;
    int shamt;
    in_exp   = int'($signed(norm_i.exponent));
    dst_exp  = in_exp + int'(cast_fmt_pkg::BIAS); // Rebiased for FP32
    shamt    = 0;
    of_range = 1'b0;
    uf_range = 1'b0;
    if (!src_is_int) begin
      // Right shift until the binary point sits below the integer
      shamt = int'(cast_fmt_pkg::INT_WIDTH) - 1 - in_exp;
      if (in_exp >= int'(cast_fmt_pkg::INT_WIDTH) - 1 + int'(norm_i.op_mod)) begin
        shamt    = 0; // Unsigned range is one bit wider
        of_range = 1'b1;
      end else if (in_exp < -1) begin
        shamt    = int'(cast_fmt_pkg::INT_WIDTH) + 1; // Everything into sticky
        uf_range = 1'b1;
      end
    end else if (dst_exp < 1 && dst_exp >= -int'(cast_fmt_pkg::MAN_BITS)) begin
      dst_exp  = 0; // Subnormal result
      shamt    = 1 - (in_exp + int'(cast_fmt_pkg::BIAS));
      uf_range = 1'b1;
    end else if (dst_exp < -int'(cast_fmt_pkg::MAN_BITS)) begin
      dst_exp  = 0;
      shamt    = 2 + int'(cast_fmt_pkg::MAN_BITS); // Keep sticky alive
      uf_range = 1'b1;
    end
    final_exp    = dst_exp[cast_fmt_pkg::EXP_BITS-1:0];
    denorm_shamt = shamt[cast_fmt_pkg::SHAMT_WIDTH-1:0];
  end

  assign dest_mant = preshift_mant >> denorm_shamt;

  // ------------------------------------------------
  // Round and sticky extraction
  // ------------------------------------------------
  // Hidden bit at the top is dropped for FP
  assign {final_mant, fp_rs[1]} =
      dest_mant[2*cast_fmt_pkg::INT_MAN_WIDTH-1 -: cast_fmt_pkg::MAN_BITS+1];
  assign {final_int, int_rs[1]} =
      dest_mant[2*cast_fmt_pkg::INT_MAN_WIDTH -: cast_fmt_pkg::INT_WIDTH+1];
  assign fp_rs[0]  = |dest_mant[2*cast_fmt_pkg::INT_MAN_WIDTH-cast_fmt_pkg::MAN_BITS-2:0];
  assign int_rs[0] = |dest_mant[2*cast_fmt_pkg::INT_MAN_WIDTH-cast_fmt_pkg::INT_WIDTH-1:0];

  assign round_sticky  = src_is_int ? fp_rs : int_rs;
  assign pre_round_abs = src_is_int ? {1'b0, final_exp, final_mant} : final_int;

  always_comb begin : round_decide
    case (norm_i.rnd_mode)
      cast_op_pkg::RNE: round_up = round_sticky[1] & (round_sticky[0] | pre_round_abs[0]);
      cast_op_pkg::RTZ: round_up = 1'b0;
      cast_op_pkg::RDN: round_up = (|round_sticky) & norm_i.sign;  // Away from zero if negative
      cast_op_pkg::RUP: round_up = (|round_sticky) & ~norm_i.sign; // Away from zero if positive
      cast_op_pkg::RMM: round_up = round_sticky[1];                // Ties away
      default:          round_up = 1'b0;
    endcase
  end

  // Mantissa carry rolls into the exponent for I2F
  assign round_sum = {1'b0, pre_round_abs} + {{cast_fmt_pkg::INT_WIDTH{1'b0}}, round_up};

  assign round_o.rounded_abs      = round_sum[cast_fmt_pkg::INT_WIDTH-1:0];
  assign round_o.rounded_sign     = norm_i.sign;
  assign round_o.fp_round_sticky  = fp_rs;
  assign round_o.int_round_sticky = int_rs;
  assign round_o.of_before_round  = of_range | round_sum[cast_fmt_pkg::INT_WIDTH]; // 32b wrap
  assign round_o.uf_before_round  = uf_range;
  assign round_o.mant_is_zero     = norm_i.mant_is_zero;
  assign round_o.is_nan           = norm_i.is_nan;
  assign round_o.is_inf           = norm_i.is_inf;
  assign round_o.op               = norm_i.op;
  assign round_o.op_mod           = norm_i.op_mod;

endmodule

//--- hw/cast_special_select.sv
/* Special cases and result selection */

`timescale 1ns/1ps

module cast_special_select (
  input  cast_op_pkg::round_t    round_i,
  output cast_op_pkg::cast_rsp_t rsp_o
);

  logic                               dst_is_int;
  logic [cast_fmt_pkg::INT_WIDTH-1:0] rounded_int_res;    // Two's complement
  logic                               int_pos_of;
  logic [cast_fmt_pkg::INT_WIDTH-1:0] int_special_result;
  logic                               int_is_special;
  logic [cast_fmt_pkg::INT_WIDTH-1:0] int_result;
  cast_op_pkg::status_t               int_status;
  cast_fmt_pkg::fp32_t                fp_packed;
  logic                               of_after_round;
  logic                               uf_after_round;
  logic [cast_fmt_pkg::FP_WIDTH-1:0]  fp_result;
  cast_op_pkg::status_t               fp_status;

  assign dst_is_int = (round_i.op == cast_op_pkg::F2I);

  // ------------------------------------------------
  // F2I
  // ------------------------------------------------
  assign rounded_int_res = round_i.rounded_sign ? -round_i.rounded_abs : round_i.rounded_abs;

  // Signed positive rounding up to 2^31
  assign int_pos_of = ~round_i.op_mod & ~round_i.rounded_sign &
                      round_i.rounded_abs[cast_fmt_pkg::INT_WIDTH-1];

  always_comb begin : int_saturate
    // Largest positive value, one bit wider for unsigned
    int_special_result = {round_i.op_mod, {(cast_fmt_pkg::INT_WIDTH - 1){1'b1}}};
    if (round_i.rounded_sign && !round_i.is_nan) begin
      int_special_result = ~int_special_result; // Most negative, or 0 for unsigned
    end
  end

  // NaN, inf, out of range, or nonzero negative into unsigned
  assign int_is_special = round_i.is_nan | round_i.is_inf | round_i.of_before_round |
                          int_pos_of |
                          (round_i.rounded_sign & round_i.op_mod & (|rounded_int_res));

  assign int_result = int_is_special ? int_special_result : rounded_int_res;

  always_comb begin
    int_status    = '0;
    int_status.NV = int_is_special;
    int_status.NX = ~int_is_special & (|round_i.int_round_sticky);
  end

  // ------------------------------------------------
  // I2F
  // ------------------------------------------------
  assign fp_packed.sign     = round_i.rounded_sign;
  assign fp_packed.exponent = round_i.rounded_abs[cast_fmt_pkg::MAN_BITS +: cast_fmt_pkg::EXP_BITS];
  assign fp_packed.mantissa = round_i.rounded_abs[cast_fmt_pkg::MAN_BITS-1:0];

  assign of_after_round = (fp_packed.exponent == '1); // Inf exponent
  assign uf_after_round = (fp_packed.exponent == '0); // Subnormal range

  assign fp_result = round_i.mant_is_zero ? '0 : fp_packed; // Integer zero is +0

  always_comb begin
    fp_status = '0;
    if (!round_i.mant_is_zero) begin
      fp_status.OF = of_after_round;
      fp_status.NX = (|round_i.fp_round_sticky) | of_after_round;
      fp_status.UF = (round_i.uf_before_round | uf_after_round) & fp_status.NX;
    end
  end

  assign rsp_o.result = dst_is_int ? int_result : fp_result;
  assign rsp_o.status = dst_is_int ? int_status : fp_status;

endmodule

//--- hw/cast_unit_top.sv
/* FP32 / INT32 converter top */

`timescale 1ns/1ps

module cast_unit_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Request side
  input  cast_op_pkg::cast_req_t req_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  // Response side
  output cast_op_pkg::cast_rsp_t rsp_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o       // Any stage occupied
);

  cast_op_pkg::cast_req_t req_q;
  cast_op_pkg::norm_t     norm_d;
  cast_op_pkg::norm_t     norm_q;
  cast_op_pkg::round_t    round_res;
  cast_op_pkg::cast_rsp_t rsp_d;
  logic                   in_valid_q;
  logic                   mid_valid_q;
  logic                   mid_ready;  // Ready back into stage 1
  logic                   out_ready;  // Ready back into stage 2

  // ------------------------------------------------
  // Stage 1, before decode
  // ------------------------------------------------
  cast_pipe_stage #(.payload_t(cast_op_pkg::cast_req_t)) u_stage_in (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(in_valid_i),
    .ready_o(in_ready_o),
    .data_i (req_i),
    .valid_o(in_valid_q),
    .ready_i(mid_ready),
    .data_o (req_q)
  );

  cast_normalize u_normalize (
    .req_i (req_q),
    .norm_o(norm_d)
  );

  // ------------------------------------------------
  // Stage 2, after normalization
  // ------------------------------------------------
  cast_pipe_stage #(.payload_t(cast_op_pkg::norm_t)) u_stage_mid (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(in_valid_q),
    .ready_o(mid_ready),
    .data_i (norm_d),
    .valid_o(mid_valid_q),
    .ready_i(out_ready),
    .data_o (norm_q)
  );

  cast_denorm_round u_denorm_round (
    .norm_i (norm_q),
    .round_o(round_res)
  );

  cast_special_select u_special_select (
    .round_i(round_res),
    .rsp_o  (rsp_d)
  );

  // ------------------------------------------------
  // Stage 3, after result selection
  // ------------------------------------------------
  cast_pipe_stage #(.payload_t(cast_op_pkg::cast_rsp_t)) u_stage_out (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(mid_valid_q),
    .ready_o(out_ready),
    .data_i (rsp_d),
    .valid_o(out_valid_o),
    .ready_i(out_ready_i),
    .data_o (rsp_o)
  );

  assign busy_o = in_valid_q | mid_valid_q | out_valid_o;

endmodule

//--- bench/cast_model.svh
/* Converter reference model */

`ifndef CAST_MODEL_SVH
`define CAST_MODEL_SVH

// Increment of a magnitude from the dropped round and sticky bits
function automatic logic decide_round_up(cast_op_pkg::rnd_mode_e mode, logic sign,
                                         logic lsb, logic rnd, logic stk);
  case (mode)
    cast_op_pkg::RNE: return rnd & (stk | lsb);   // Tie goes to even
    cast_op_pkg::RTZ: return 1'b0;
    cast_op_pkg::RDN: return (rnd | stk) & sign;  // Negative moves away from zero
    cast_op_pkg::RUP: return (rnd | stk) & ~sign;
    cast_op_pkg::RMM: return rnd;                 // Tie goes away from zero
    default:          return 1'b0;
  endcase
endfunction

function automatic cast_op_pkg::cast_rsp_t float_to_int(logic [31:0] word, logic unsgn,
                                                       cast_op_pkg::rnd_mode_e mode);
  cast_op_pkg::cast_rsp_t rsp;
  logic                   sign;
  logic [7:0]             exp_f;
  longint unsigned        sig;
  longint unsigned        ipart;
  longint unsigned        mag;
  int                     scale;
  int                     msb;
  int                     sh;
  logic                   rnd;
  logic                   stk;
  logic                   up;
  logic                   special;
  rsp   = '0;
  sign  = word[31];
  exp_f = word[30:23];
  sig   = {40'd0, exp_f != 8'd0, word[22:0]};      // Hidden bit only when normal
  scale = ((exp_f == 8'd0) ? 1 : int'(exp_f)) - 150; // Value is sig * 2^scale
  msb   = -1;
  ipart = 64'd0;
  rnd   = 1'b0;
  stk   = 1'b0;
  for (int i = 0; i < 24; i++) begin
    if (sig[i]) begin
      msb = i;
    end
  end
  // Inf, NaN, or leading one at or above 2^31 (2^32 unsigned)
  special = (exp_f == 8'hFF) || (sig != 64'd0 && msb + scale >= 31 + int'(unsgn));
  if (!special && scale >= 0) begin
    ipart = sig << scale; // Whole number
  end else if (!special && -scale > 25) begin
    stk = (sig != 64'd0); // Well below one half
  end else if (!special) begin
    sh    = -scale;
    ipart = sig >> sh;
    rnd   = sig[sh-1];
    stk   = (sig & ((64'd1 << (sh - 1)) - 64'd1)) != 64'd0;
  end
  up  = decide_round_up(mode, sign, ipart[0], rnd, stk);
  mag = ipart + {63'd0, up};
  if (!special && unsgn) begin
    special = sign ? (mag != 64'd0) : (mag > 64'hFFFF_FFFF); // Negative nonzero is invalid
  end else if (!special) begin
    special = sign ? (mag > 64'h8000_0000) : (mag > 64'h7FFF_FFFF);
  end
  if (special && exp_f == 8'hFF && word[22:0] != 23'd0) begin
    rsp.result = unsgn ? 32'hFFFF_FFFF : 32'h7FFF_FFFF; // NaN saturates high
  end else if (special) begin
    rsp.result = sign ? (unsgn ? 32'h0000_0000 : 32'h8000_0000)
                      : (unsgn ? 32'hFFFF_FFFF : 32'h7FFF_FFFF);
  end else begin
    rsp.result = sign ? -mag[31:0] : mag[31:0];
  end
  rsp.status.NV = special;
  rsp.status.NX = ~special & (rnd | stk);
  return rsp;
endfunction

function automatic cast_op_pkg::cast_rsp_t int_to_float(logic [31:0] word, logic unsgn,
                                                       cast_op_pkg::rnd_mode_e mode);
  cast_op_pkg::cast_rsp_t rsp;
  logic                   sign;
  longint unsigned        mag;
  longint unsigned        sig;
  longint unsigned        bits;
  int                     msb;
  int                     sh;
  logic                   rnd;
  logic                   stk;
  logic                   up;
  rsp  = '0;
  sign = word[31] & ~unsgn;
  mag  = sign ? 64'h1_0000_0000 - {32'd0, word} : {32'd0, word};
  msb  = 0;
  rnd  = 1'b0;
  stk  = 1'b0;
  for (int i = 0; i < 32; i++) begin
    if (mag[i]) begin
      msb = i;
    end
  end
  if (msb > 23) begin
    sh  = msb - 23; // Bits that do not fit the 24 bit significand
    sig = mag >> sh;
    rnd = mag[sh-1];
    stk = (mag & ((64'd1 << (sh - 1)) - 64'd1)) != 64'd0;
  end else begin
    sig = mag << (23 - msb);
  end
  // Exponent next to the fraction so a carry bumps the exponent
  bits = (64'(msb + 127) << 23) | (sig & 64'h7F_FFFF);
  up   = decide_round_up(mode, sign, sig[0], rnd, stk);
  bits = bits + {63'd0, up};
  if (mag != 64'd0) begin
    rsp.result    = {sign, bits[30:0]};
    rsp.status.NX = rnd | stk;
  end
  return rsp;
endfunction

function automatic cast_op_pkg::cast_rsp_t expected_rsp(cast_op_pkg::cast_req_t item);
  if (item.op == cast_op_pkg::I2F) begin
    return int_to_float(item.operand.ival, item.op_mod, item.rnd_mode);
  end else begin
    return float_to_int(item.operand.ival, item.op_mod, item.rnd_mode);
  end
endfunction

// ------------------------------------------------
// Random requests, weighted toward the interesting ranges
// ------------------------------------------------
function automatic cast_op_pkg::cast_req_t random_request();
  cast_op_pkg::cast_req_t item;
  int unsigned            kind;
  logic [31:0]            word;
  item          = '0;
  kind          = $urandom_range(9, 0);
  word          = $urandom;
  item.op       = ($urandom % 2 != 0) ? cast_op_pkg::I2F : cast_op_pkg::F2I;
  item.op_mod   = 1'($urandom % 2);
  item.rnd_mode = cast_op_pkg::rnd_mode_e'(3'($urandom % 5));
  if (item.op == cast_op_pkg::F2I) begin
    case (kind)
      0:       word[30:23] = 8'h00;                  // Zero or subnormal
      1:       word[30:23] = 8'hFF;                  // Inf or NaN
      2, 3:    word[30:23] = 8'(158 + $urandom % 97); // 2^31 and up
      default: word[30:23] = 8'(100 + $urandom % 58); // Below 2^31, fraction bits
    endcase
  end else if (kind == 0) begin
    word = word & 32'h0000_00FF; // Exact small integers
  end
  item.operand.ival = word;
  return item;
endfunction

`endif

//--- bench/cast_tb.sv
/* Converter testbench */

`timescale 1ns/1ps

module cast_tb;

  localparam int SEED       = 46640;
  localparam int TIMEOUT    = 200;  // Cycles allowed for any wait
  localparam int NUM_RANDOM = 1500;
  localparam int NUM_SENT   = 1 + 17 * 2 * 2 * 5 + NUM_RANDOM; // Lone, edge sweep, random

  // Edge operands, each run as float and as integer
  localparam logic [31:0] EDGE_WORDS [17] = '{
    32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF,
    32'h7FC0_0000, 32'h7F80_0001, 32'h7F80_0000, 32'hFF80_0000, 32'h4F00_0000,
    32'hCF00_0000, 32'h4F80_0000, 32'hBFC0_0000, 32'h4020_0000, 32'h3F00_0000,
    32'hBE80_0000, 32'h0100_0001
  };

  logic                   clk;
  logic                   rst;
  cast_op_pkg::cast_req_t req;
  logic                   in_valid;
  logic                   in_ready;
  cast_op_pkg::cast_rsp_t rsp;
  logic                   out_valid;
  logic                   out_ready;
  logic                   busy;
  logic                   bp_en;     // Random stalls on the response side

  cast_op_pkg::cast_rsp_t exp_q [$]; // Expected responses, oldest first
  int check_count  = 0;
  int value_errors = 0;
  int other_errors = 0;
  int req_count    = 0;
  int rsp_count    = 0;

  `include "cast_model.svh"

  cast_unit_top u_dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .in_valid_i (in_valid),
    .in_ready_o (in_ready),
    .rsp_o      (rsp),
    .out_valid_o(out_valid),
    .out_ready_i(out_ready),
    .busy_o     (busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    check_count++;
    if (got !== want) begin
      value_errors++;
      $display("FAIL at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, want);
    end
  endtask

  task automatic finish_run();
    $display("Checks %0d, value errors %0d, other errors %0d, requests %0d, responses %0d",
             check_count, value_errors, other_errors, req_count, rsp_count);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // Returns at the edge where the offered request is taken
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!(in_valid && in_ready)) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout at %0t: request not accepted in %0d cycles", $time, TIMEOUT);
        other_errors++;
        finish_run();
      end
      @(posedge clk);
    end
  endtask

  task automatic send_request(input cast_op_pkg::cast_req_t item);
    if ($urandom % 4 == 0) begin
      in_valid <= 1'b0; // Idle bubble between requests
      @(posedge clk);
    end
    req      <= item;
    in_valid <= 1'b1;
    wait_accept();
  endtask

  // ------------------------------------------------
  // Response side stalls, about 30% when enabled
  // ------------------------------------------------
  initial begin : backpressure
    out_ready <= 1'b1;
    forever begin
      @(posedge clk);
      out_ready <= bp_en ? (($urandom % 100) >= 30) : 1'b1;
    end
  end

  // Scoreboard, sampled on the edge with pre-edge values
  always @(posedge clk) begin : scoreboard
    cast_op_pkg::cast_rsp_t want;
    if (!rst) begin
      check_val("busy_o", 32'(busy), 32'(exp_q.size() != 0)); // Busy iff in flight
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response at %0t arrived with no request pending", $time);
          other_errors++;
        end else begin
          want = exp_q.pop_front();
          check_val("rsp_o.result", rsp.result, want.result);
          check_val("rsp_o.status", 32'(rsp.status), 32'(want.status));
          rsp_count++;
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_rsp(req));
        req_count++;
      end
    end
  end

  initial begin : main
    cast_op_pkg::cast_req_t one;
    int                     edges;
    int                     cycles;
    void'($urandom(SEED));
    rst      <= 1'b1;
    in_valid <= 1'b0;
    req      <= '0;
    bp_en    <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_val("out_valid_o", 32'(out_valid), 32'd0); // Empty after reset
    check_val("busy_o", 32'(busy), 32'd0);
    check_val("in_ready_o", 32'(in_ready), 32'd1);

    // ------------------------------------------------
    // Lone request, latency and busy
    // ------------------------------------------------
    @(posedge clk);
    req      <= random_request();
    in_valid <= 1'b1;
    wait_accept();
    in_valid <= 1'b0;
    edges = 0;
    do begin
      @(negedge clk);
      edges++; // Edges since acceptance, that one included
      check_val("busy_o", 32'(busy), 32'd1);
      if (edges > TIMEOUT) begin
        $display("Timeout at %0t: no response to the lone request", $time);
        other_errors++;
        finish_run();
      end
    end while (!out_valid);
    check_val("latency in edges", 32'(edges), 32'd3);
    @(negedge clk);
    check_val("out_valid_o", 32'(out_valid), 32'd0);
    check_val("busy_o", 32'(busy), 32'd0);

    // Edge operands under all ops, signedness and modes, then random
    @(posedge clk);
    bp_en <= 1'b1;
    for (int w = 0; w < 17; w++) begin
      for (int op = 0; op < 2; op++) begin
        for (int md = 0; md < 2; md++) begin
          for (int rm = 0; rm < 5; rm++) begin
            one               = '0;
            one.operand.ival  = EDGE_WORDS[w];
            one.op            = (op == 1) ? cast_op_pkg::I2F : cast_op_pkg::F2I;
            one.op_mod        = 1'(md);
            one.rnd_mode      = cast_op_pkg::rnd_mode_e'(3'(rm));
            send_request(one);
          end
        end
      end
    end
    repeat (NUM_RANDOM) send_request(random_request());
    in_valid <= 1'b0;

    // Drain whatever is still in the pipeline
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
        other_errors++;
        finish_run();
      end
    end
    bp_en <= 1'b0;
    repeat (4) @(negedge clk);
    check_val("out_valid_o", 32'(out_valid), 32'd0); // Nothing duplicated
    check_val("response count", 32'(rsp_count), 32'(NUM_SENT));
    finish_run();
  end

endmodule

//--- verilog.f
+incdir+bench
hw/cast_fmt_pkg.sv
hw/cast_op_pkg.sv
hw/cast_pipe_stage.sv
hw/cast_normalize.sv
hw/cast_denorm_round.sv
hw/cast_special_select.sv
hw/cast_unit_top.sv
bench/cast_tb.sv

//--- Makefile
# Verilator build and run for the FP32/INT32 converter

VERILATOR ?= verilator
TOP       ?= cast_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
